//--- Bender.yml
package:
  name: text_video

sources:
  - files:
      - logic/videoPkg.sv
      - logic/cycleSequencer.sv
      - logic/charLoader.sv
      - logic/charBuffer.sv
      - logic/pixelShifter.sv
      - logic/textVideo.sv
  - target: test
    files:
      - verification/textVideoChk.sv
      - verification/textVideoTb.sv

//--- logic/charBuffer.sv
module charBuffer
	import videoPkg::*;
#(
	parameter int COLS = 40
) (
	input  logic     clk33,
	input  logic     rst,
	input  logic     push,
	input  charWordT din,
	output charWordT propChar
);

	// One entry per display column
	charWordT store [COLS];
	logic pushDly;

	// The loader's register updates on the push cycle itself
	// so the word is taken one cycle later once it is settled
	always_ff @(posedge clk33) begin
		if (rst)
			pushDly <= 1'b0;
		else
			pushDly <= push;
	end

	always_ff @(posedge clk33) begin
		if (rst) begin
			for (int i = 0; i < COLS; i++)
				store[i] <= '0;
		end else if (pushDly) begin
			store[0] <= din;
			for (int i = 1; i < COLS; i++)
				store[i] <= store[i-1];
		end
	end

	// After COLS loads the tail is this column's word from the line above
	assign propChar = store[COLS-1];

endmodule

//--- logic/charLoader.sv
module charLoader
	import videoPkg::*;
(
	input  logic        clk33,
	input  logic        rst,
	input  logic        phi02,
	input  logic        enaData,
	input  logic        badline,
	input  vicCycleT    phase,
	input  logic [11:0] db,
	input  charWordT    propChar,
	output charWordT    char
);

	// Capture window of the character fetch
	// It is only open during the data phase of a display column
	logic capture;

	assign capture = phi02 && enaData && (phase == VIC_CHAR);

	// ====================
	// Word select
	// ====================

	// On a badline the word comes straight from screen memory
	// Otherwise the same column of the line above is reused
	// The word holds from the graphics phase to the next capture,
	// which covers both the ROM address and the colour decode
	always_ff @(posedge clk33) begin
		if (rst) begin
			char <= '0;
		end else if (capture) begin
			if (badline)
				char <= charWordT'(db);
			else
				char <= propChar;
		end
	end

endmodule

//--- logic/cycleSequencer.sv
module cycleSequencer
	import videoPkg::*;
#(
	parameter int COLS = 40,
	parameter int ROWS = 25,
	parameter int HBLANK_SLOTS = 23,
	parameter int LINES = 262,
	parameter int TOP_LINE = 51
) (
	input  logic      clk33,
	input  logic      rst,
	input  videoRegsT regs,
	input  charWordT  char,
	output vicCycleT  phase,
	output logic      phi02,
	output logic      enaData,
	output logic      badline,
	output logic      gfxStrobe,
	output logic      shiftLoad,
	output logic      active,
	output logic      newLine,
	output logic      newFrame,
	output busReqT    bus
);

	localparam int SLOTS = COLS + HBLANK_SLOTS;
	localparam int COL_W = $clog2(SLOTS);
	localparam int LINE_W = $clog2(LINES);
	localparam int ROW_W = $clog2(ROWS + 1);
	localparam logic [2:0] LAST_PH = 3'(SLOT_CYCLES - 1);

	// Raster position, one cycle ahead of the registered strobes
	logic [2:0] slotPh;
	logic [COL_W-1:0] col;
	logic [LINE_W-1:0] line;
	logic [LINE_W-1:0] nextLine;
	// Text row of the next badline and pixel row inside the cell
	logic [ROW_W-1:0] textRow;
	logic [2:0] rowCount;

	logic dispCol;
	logic slotEnd;
	logic lineEnd;
	logic frameEnd;
	logic inWin;
	logic isBad;
	logic nextBad;
	logic pixOn;

	logic scrReq;
	logic gfxReq;
	logic [13:0] scrAddr;
	logic [7:0] gfxCode;

	function automatic logic winLine(input logic [LINE_W-1:0] l);
		return (int'(l) >= TOP_LINE) && (int'(l) < TOP_LINE + ROWS * 8);
	endfunction

	always_comb begin
		dispCol = int'(col) < COLS;
		slotEnd = slotPh == LAST_PH;
		lineEnd = slotEnd && (int'(col) == SLOTS - 1);
		frameEnd = lineEnd && (int'(line) == LINES - 1);
		nextLine = frameEnd ? '0 : line + 1'b1;
		inWin = winLine(line);
		// A badline is any window line whose fine position matches yScroll
		isBad = inWin && (line[2:0] == regs.yScroll);
		nextBad = winLine(nextLine) && (nextLine[2:0] == regs.yScroll);
		// The column being shifted out is this one on the last phase
		// and the previous one for the rest of the slot
		if (slotEnd)
			pixOn = dispCol;
		else
			pixOn = (col != '0) && (int'(col) <= COLS);
		pixOn = pixOn && inWin;
	end

	// ====================
	// Raster counters
	// ====================

	always_ff @(posedge clk33) begin
		if (rst) begin
			slotPh <= '0;
			col <= '0;
			line <= '0;
			textRow <= '0;
			rowCount <= '0;
		end else begin
			slotPh <= slotEnd ? '0 : slotPh + 1'b1;
			if (slotEnd)
				col <= lineEnd ? '0 : col + 1'b1;
			if (lineEnd) begin
				line <= nextLine;
				// Each badline consumes one row of screen memory
				if (frameEnd)
					textRow <= '0;
				else if (isBad)
					textRow <= textRow + 1'b1;
				if (nextBad)
					rowCount <= '0;
				else if (winLine(nextLine))
					rowCount <= rowCount + 1'b1;
			end
		end
	end

	// ====================
	// Slot strobes
	// ====================

	// Every strobe is registered, so the outside sees slot phase p
	// one cycle after slotPh held p
	always_ff @(posedge clk33) begin
		if (rst) begin
			phase <= VIC_IDLE;
			phi02 <= 1'b0;
			enaData <= 1'b0;
			badline <= 1'b0;
			scrReq <= 1'b0;
			gfxReq <= 1'b0;
			gfxStrobe <= 1'b0;
			shiftLoad <= 1'b0;
			active <= 1'b0;
			newLine <= 1'b0;
			newFrame <= 1'b0;
		end else begin
			phi02 <= slotPh <= PH_GCAP;
			enaData <= slotPh == PH_DATA;
			badline <= isBad;
			// Character words circulate on every line so the buffer
			// always holds the previous line
			if (dispCol && slotPh <= PH_DATA)
				phase <= VIC_CHAR;
			else if (dispCol && inWin && (slotPh == PH_GFX || slotPh == PH_GCAP))
				phase <= VIC_GFX;
			else
				phase <= VIC_IDLE;
			scrReq <= dispCol && isBad && (slotPh == PH_CHAR);
			gfxReq <= dispCol && inWin && (slotPh == PH_GFX);
			gfxStrobe <= dispCol && inWin && (slotPh == PH_GCAP);
			shiftLoad <= dispCol && inWin && slotEnd;
			active <= pixOn;
			// Line and frame marks ride on the first pixel of column 0
			newLine <= inWin && slotEnd && (col == '0);
			newFrame <= inWin && slotEnd && (col == '0) && (int'(line) == TOP_LINE);
		end
	end

	always_ff @(posedge clk33) begin
		if (slotPh == PH_CHAR)
			scrAddr <= 14'(int'(textRow) * COLS + int'(col));
	end

	// The ROM address follows the word the loader has just captured
	always_comb begin
		gfxCode = regs.ecm ? {2'b00, char.ecmChar.code} : char.stdChar.code;
		bus = '0;
		if (scrReq) begin
			bus.sel = 1'b0;
			bus.addr = scrAddr;
		end else if (gfxReq) begin
			bus.sel = 1'b1;
			bus.addr = {3'b000, gfxCode, rowCount};
		end
	end

endmodule

//--- logic/pixelShifter.sv
module pixelShifter
	import videoPkg::*;
(
	input  logic        clk33,
	input  logic        rst,
	input  logic        gfxStrobe,
	input  logic        shiftLoad,
	input  logic        active,
	input  logic        newLine,
	input  logic        newFrame,
	input  videoRegsT   regs,
	input  logic [11:0] db,
	input  charWordT    char,
	output pixelT       pixel
);

	// Graphics byte waiting for the end of the slot
	logic [7:0] gfxByte;
	// Remaining bits of the column being shown
	logic [7:0] shiftReg;
	logic [3:0] fgCur;
	logic [3:0] bgCur;
	logic [3:0] fgNext;
	logic [3:0] bgNext;

	// ====================
	// Colour decode
	// ====================

	// The colour nibble sits at the same place in both views
	// Only the background source differs between the modes
	always_comb begin
		fgNext = char.stdChar.color;
		if (regs.ecm)
			bgNext = regs.bgColor[char.ecmChar.bgSel];
		else
			bgNext = regs.bgColor[0];
	end

	// ROM data shows up on the low byte of db
	always_ff @(posedge clk33) begin
		if (gfxStrobe)
			gfxByte <= db[7:0];
	end

	// ====================
	// Shift out
	// ====================

	// Bit 7 goes out directly on the load so the first pixel is
	// not held back by a cycle
	always_ff @(posedge clk33) begin
		if (rst) begin
			shiftReg <= '0;
			fgCur <= '0;
			bgCur <= '0;
			pixel <= '0;
		end else begin
			pixel.active <= active;
			pixel.newLine <= newLine;
			pixel.newFrame <= newFrame;
			if (shiftLoad) begin
				shiftReg <= {gfxByte[6:0], 1'b0};
				fgCur <= fgNext;
				bgCur <= bgNext;
				pixel.color <= gfxByte[7] ? fgNext : bgNext;
			end else begin
				shiftReg <= {shiftReg[6:0], 1'b0};
				pixel.color <= shiftReg[7] ? fgCur : bgCur;
			end
		end
	end

endmodule

//--- logic/textVideo.sv
module textVideo
	import videoPkg::*;
#(
	parameter int COLS = 40,
	parameter int ROWS = 25,
	parameter int HBLANK_SLOTS = 23,
	parameter int LINES = 262,
	parameter int TOP_LINE = 51
) (
	input  logic        clk33,
	input  logic        rst,
	input  videoRegsT   regs,
	input  logic [11:0] db,
	output busReqT      bus,
	output pixelT       pixel
);

	vicCycleT phase;
	logic phi02;
	logic enaData;
	logic badline;
	logic gfxStrobe;
	logic shiftLoad;
	logic active;
	logic newLine;
	logic newFrame;
	logic push;
	charWordT char;
	charWordT propChar;

	// The buffer steps together with every character capture
	assign push = phi02 && enaData && (phase == VIC_CHAR);

	// ====================
	// Fetch path
	// ====================

	cycleSequencer #(
		.COLS(COLS),
		.ROWS(ROWS),
		.HBLANK_SLOTS(HBLANK_SLOTS),
		.LINES(LINES),
		.TOP_LINE(TOP_LINE)
	) sequencer (
		.clk33(clk33),
		.rst(rst),
		.regs(regs),
		.char(char),
		.phase(phase),
		.phi02(phi02),
		.enaData(enaData),
		.badline(badline),
		.gfxStrobe(gfxStrobe),
		.shiftLoad(shiftLoad),
		.active(active),
		.newLine(newLine),
		.newFrame(newFrame),
		.bus(bus)
	);

	charLoader loader (
		.clk33(clk33),
		.rst(rst),
		.phi02(phi02),
		.enaData(enaData),
		.badline(badline),
		.phase(phase),
		.db(db),
		.propChar(propChar),
		.char(char)
	);

	charBuffer #(
		.COLS(COLS)
	) buffer (
		.clk33(clk33),
		.rst(rst),
		.push(push),
		.din(char),
		.propChar(propChar)
	);

	// Pixel output stage
	pixelShifter shifter (
		.clk33(clk33),
		.rst(rst),
		.gfxStrobe(gfxStrobe),
		.shiftLoad(shiftLoad),
		.active(active),
		.newLine(newLine),
		.newFrame(newFrame),
		.regs(regs),
		.db(db),
		.char(char),
		.pixel(pixel)
	);

endmodule

//--- logic/videoPkg.sv
package videoPkg;

	// ====================
	// Slot timing
	// ====================

	// Number of clk33 cycles in one character slot
	localparam int SLOT_CYCLES = 8;

	// Slot phases where the sequencer issues its strobes
	// The screen request goes out on PH_CHAR and its data comes back on PH_DATA
	localparam logic [2:0] PH_CHAR = 3'd0;
	localparam logic [2:0] PH_DATA = 3'd1;
	// The ROM request goes out on PH_GFX and the byte is captured on PH_GCAP
	localparam logic [2:0] PH_GFX = 3'd2;
	localparam logic [2:0] PH_GCAP = 3'd3;

	// Bus phase of the current slot as seen by the loader
	typedef enum logic [1:0] {
		VIC_IDLE,
		VIC_CHAR,
		VIC_GFX
	} vicCycleT;

	// ====================
	// Character words
	// ====================

	// Standard text mode with a full 256 character set
	typedef struct packed {
		logic [3:0] color;
		logic [7:0] code;
	} stdCharT;

	// Extended background mode gives up the top two code bits
	// They pick one of four background colours instead
	typedef struct packed {
		logic [3:0] color;
		logic [1:0] bgSel;
		logic [5:0] code;
	} ecmCharT;

	// One screen word, read through whichever view the mode asks for
	typedef union packed {
		stdCharT stdChar;
		ecmCharT ecmChar;
	} charWordT;

	// ====================
	// Registers, bus and pixels
	// ====================

	typedef struct packed {
		logic ecm;
		logic [2:0] yScroll;
		logic [3:0][3:0] bgColor;
	} videoRegsT;

	// sel is low for screen memory and high for character ROM
	typedef struct packed {
		logic sel;
		logic [13:0] addr;
	} busReqT;

	typedef struct packed {
		logic active;
		logic newLine;
		logic newFrame;
		logic [3:0] color;
	} pixelT;

endpackage

//--- project.f
logic/videoPkg.sv
logic/cycleSequencer.sv
logic/charLoader.sv
logic/charBuffer.sv
logic/pixelShifter.sv
logic/textVideo.sv
verification/textVideoChk.sv
verification/textVideoTb.sv

//--- verification/textVideoChk.sv
module textVideoChk
	import videoPkg::*;
#(
	parameter int COLS = 40,
	parameter int ROWS = 25,
	parameter int HBLANK_SLOTS = 23,
	parameter int LINES = 262,
	parameter int TOP_LINE = 51
) (
	input  logic        clk33,
	input  logic        rst,
	input  videoRegsT   regs,
	input  logic [11:0] db,
	input  busReqT      bus,
	input  pixelT       pixel,
	input  logic        phi02,
	input  logic        enaData,
	input  logic        badline,
	input  logic        gfxStrobe,
	input  charWordT    char
);

	localparam int SLOTS = COLS + HBLANK_SLOTS;
	localparam int LINE_CYCLES = SLOTS * SLOT_CYCLES;

	// Count of failed assertions
	int failCount = 0;
	// Cycle index in the bus timeline
	// It is zero on the first phase-0 slot after reset
	int cyc;
	int extPh;
	int col;
	int line;
	int firstBad;
	int row;
	int rowCnt;
	logic inWin;
	logic expBad;
	logic [11:0] charBits;
	logic [7:0] code;
	logic [3:0] bgExp;

	always_ff @(posedge clk33) begin
		if (rst)
			cyc <= -1;
		else
			cyc <= cyc + 1;
	end

	// ====================
	// Reference raster
	// ====================

	always_comb begin
		extPh = cyc % SLOT_CYCLES;
		col = (cyc / SLOT_CYCLES) % SLOTS;
		line = (cyc / LINE_CYCLES) % LINES;
		inWin = (cyc >= 0) && (line >= TOP_LINE) && (line < TOP_LINE + ROWS * 8);
		expBad = inWin && ((line % 8) == int'(regs.yScroll));
		// The first badline of the window fixes the text row and the cell row
		firstBad = TOP_LINE + ((int'(regs.yScroll) - TOP_LINE) & 7);
		row = (line - firstBad) / 8;
		rowCnt = (line - int'(regs.yScroll)) & 7;
		// Colour sits in bits 11 to 8 of the word
		// The code is the low eight bits, or the low six with bgSel above them
		charBits = char;
		code = regs.ecm ? {2'b00, charBits[5:0]} : charBits[7:0];
		bgExp = regs.bgColor[regs.ecm ? charBits[7:6] : 2'd0];
	end

	// ====================
	// Bus and loader
	// ====================

	// Outputs stay quiet while reset is held
	resetQuiet: assert property (@(posedge clk33)
		rst && $past(rst) |-> !pixel.active && !phi02 && !enaData && bus == '0)
	else begin
		failCount++;
		$error("FAILED t=%0t: outputs not idle during reset", $time);
	end

	// A badline fetches from screen memory and the loader takes the answer
	screenFetch: assert property (@(posedge clk33) disable iff (rst)
		extPh == 0 && col < COLS && expBad
		|-> bus.sel == 1'b0 && bus.addr == 14'(row * COLS + col) ##2 char == $past(db))
	else begin
		failCount++;
		$error("FAILED t=%0t: screen fetch of column %0d line %0d", $time, col, line);
	end

	// Other window lines repeat the word of the same column one line earlier
	recirculate: assert property (@(posedge clk33) disable iff (rst)
		extPh == 2 && col < COLS && inWin && !expBad |-> char == $past(char, LINE_CYCLES))
	else begin
		failCount++;
		$error("FAILED t=%0t: word of column %0d not repeated on line %0d", $time, col, line);
	end

	gfxFetch: assert property (@(posedge clk33) disable iff (rst)
		extPh == 2 && col < COLS && inWin
		|-> bus.sel == 1'b1 && (line < firstBad || bus.addr == 14'(int'(code) * 8 + rowCnt)))
	else begin
		failCount++;
		$error("FAILED t=%0t: ROM address 0x%0h on line %0d", $time, bus.addr, line);
	end

	badlinePlace: assert property (@(posedge clk33) disable iff (rst)
		cyc >= 0 |-> badline == expBad)
	else begin
		failCount++;
		$error("FAILED t=%0t: badline is %0b on line %0d", $time, badline, line);
	end

	// ====================
	// Pixel colours
	// ====================

	// Pixels of column c fill slot c+1 and the marks ride on its first pixel
	pixelMarks: assert property (@(posedge clk33) disable iff (rst)
		cyc >= 0 |-> pixel.active == (inWin && col >= 1 && col <= COLS)
			&& pixel.newLine == (inWin && col == 1 && extPh == 0)
			&& pixel.newFrame == (inWin && col == 1 && extPh == 0 && line == TOP_LINE))
	else begin
		failCount++;
		$error("FAILED t=%0t: pixel marks wrong at column %0d line %0d", $time, col, line);
	end

	// Bit 7-p of the captured byte leaves the top 5+p cycles after capture
	for (genvar p = 0; p < 8; p++) begin : pixelBit
		pixelColor: assert property (@(posedge clk33) disable iff (rst)
			gfxStrobe |-> ##(5 + p) pixel.active && pixel.color ==
				($past(db[7-p], 5 + p) ? $past(charBits[11:8], 5 + p) : $past(bgExp, 5 + p)))
		else begin
			failCount++;
			$error("FAILED t=%0t: pixel %0d has colour %0h", $time, p, pixel.color);
		end
	end

endmodule

//--- verification/textVideoTb.sv
module textVideoTb
	import videoPkg::*;
();

	localparam int COLS = 8;
	localparam int ROWS = 3;
	localparam int HBLANK_SLOTS = 2;
	localparam int LINES = 40;
	localparam int TOP_LINE = 4;
	localparam int LINE_CYCLES = (COLS + HBLANK_SLOTS) * SLOT_CYCLES;
	localparam int FRAME_CYCLES = LINES * LINE_CYCLES;
	localparam int MEM_WORDS = 16384;

	logic clk33;
	logic rst;
	videoRegsT regs;
	logic [11:0] db;
	busReqT bus;
	pixelT pixel;

	// Screen memory and character ROM share the 14-bit address space
	logic [11:0] screenMem [MEM_WORDS];
	logic [7:0] charRom [MEM_WORDS];
	busReqT lastReq;
	int seed;
	int tbErrors;
	int badSeen;
	logic timedOut;

	textVideo #(
		.COLS(COLS),
		.ROWS(ROWS),
		.HBLANK_SLOTS(HBLANK_SLOTS),
		.LINES(LINES),
		.TOP_LINE(TOP_LINE)
	) UUT (
		.clk33(clk33),
		.rst(rst),
		.regs(regs),
		.db(db),
		.bus(bus),
		.pixel(pixel)
	);

	bind textVideo textVideoChk #(
		.COLS(COLS),
		.ROWS(ROWS),
		.HBLANK_SLOTS(HBLANK_SLOTS),
		.LINES(LINES),
		.TOP_LINE(TOP_LINE)
	) protocolCheck (
		.clk33(clk33),
		.rst(rst),
		.regs(regs),
		.db(db),
		.bus(bus),
		.pixel(pixel),
		.phi02(phi02),
		.enaData(enaData),
		.badline(badline),
		.gfxStrobe(gfxStrobe),
		.char(char)
	);

	initial begin
		clk33 = 1'b0;
		forever #5 clk33 = ~clk33;
	end

	// ====================
	// Memory model
	// ====================

	// The request seen in one cycle is answered on db in the next one
	always @(negedge clk33) begin
		if (lastReq.sel)
			db <= {4'h0, charRom[lastReq.addr]};
		else
			db <= screenMem[lastReq.addr];
		lastReq <= bus;
		if (UUT.badline && regs.yScroll == 3'd3)
			badSeen++;
	end

	task automatic waitFrameStart();
		int n;
		n = 0;
		while (!timedOut && !pixel.newFrame) begin
			@(negedge clk33);
			n++;
			if (n > FRAME_CYCLES + LINE_CYCLES) begin
				timedOut = 1'b1;
				$display("Timeout: no frame start seen within %0d cycles", n);
			end
		end
	endtask

	// The window is over once active stays low for more than a whole line
	task automatic waitWindowEnd();
		int n;
		int idle;
		n = 0;
		idle = 0;
		while (!timedOut && idle <= LINE_CYCLES) begin
			@(negedge clk33);
			n++;
			idle = pixel.active ? 0 : idle + 1;
			if (n > FRAME_CYCLES) begin
				timedOut = 1'b1;
				$display("Timeout: display window did not end within %0d cycles", n);
			end
		end
	endtask

	task automatic runFrames(input int count);
		for (int i = 0; i < count; i++) begin
			waitFrameStart();
			waitWindowEnd();
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin
		rst = 1'b1;
		regs = '0;
		db = '0;
		lastReq = '0;
		tbErrors = 0;
		badSeen = 0;
		timedOut = 1'b0;
		seed = 32'he1ca;
		for (int a = 0; a < MEM_WORDS; a++) begin
			screenMem[a] = 12'($random(seed));
			charRom[a] = 8'($random(seed));
		end
		regs.bgColor = 16'($random(seed));
		repeat (8) @(posedge clk33);
		@(negedge clk33);
		rst = 1'b0;
		// Standard mode first, then extended background with a scrolled row
		runFrames(2);
		@(negedge clk33);
		regs.ecm = 1'b1;
		regs.yScroll = 3'd3;
		runFrames(2);
		if (!timedOut && badSeen == 0) begin
			tbErrors++;
			$display("No badline was reached while yScroll was 3");
		end
		$display("Closing report: %0d assertion errors, %0d testbench errors, timeout %0d",
			UUT.protocolCheck.failCount, tbErrors, timedOut);
		if (timedOut || tbErrors != 0 || UUT.protocolCheck.failCount != 0)
			$display("TESTBENCH FAILED");
		else
			$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
